// ==== hski2c_top.f ====
hski2c_pkg.sv
hsk_wb_ctrl.sv
hsk_watchdog.sv
hsk_port_decode.sv
hski2c_top.sv
hski2c_checker.sv
tb_hski2c_top.sv

// ==== Bender.yml ====
package:
  name: hski2c

sources:
  - files:
      - hski2c_pkg.sv
      - hsk_wb_ctrl.sv
      - hsk_watchdog.sv
      - hsk_port_decode.sv
      - hski2c_top.sv
  - target: simulation
    files:
      - hski2c_checker.sv
      - tb_hski2c_top.sv

// ==== tb_hski2c_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_hski2c_top;

    // one line of the stimulus table
    typedef struct packed {
        logic [127:0] name;
        logic         sys_rst;
        // write, k_write, read
        logic [2:0]   strb;
        logic [7:0]   port_id;
        logic [7:0]   out_port;
        logic         wb_wr;
        logic [3:0]   wb_sel;
        logic [15:0]  wb_dat;
        // conf[1:0], scl, sda, hsk_enable, cratebridge_en
        logic [5:0]   pins;
        logic         lane_up;
        logic [7:0]   cycles;
        // keep going until the outputs match, up to cycles
        logic         wait_hit;
        logic [7:0]   exp_in_port;
        // wd_disable, cratebridge_actual, processor_reset
        logic [2:0]   exp_ctrl;
        // sda_t, scl_t, hsk_enable_t, hsk_enable, cratebridge_en, interrupt
        logic [5:0]   exp_pins;
    } row_t;

    logic                wb_clk_i;
    logic                sys_rst_i;
    hski2c_pkg::wb_req_t wb_i;
    hski2c_pkg::pb_bus_t pb_i;
    logic [1:0]          conf_i;
    logic                sda_i;
    logic                scl_i;
    logic                hsk_enable_i;
    logic                cratebridge_en_i;
    logic                lane_up_i;
    hski2c_pkg::wb_rsp_t wb_o;
    logic [7:0]          in_port_o;
    logic                sda_t_o;
    logic                scl_t_o;
    logic                hsk_enable_t_o;
    logic                hsk_enable_o;
    logic                cratebridge_en_o;
    logic                interrupt_o;

    // checker side
    logic         check_en;
    logic         wait_en;
    logic         last_cycle;
    logic [127:0] test_name;
    logic [7:0]   exp_in_port;
    logic [2:0]   exp_ctrl;
    logic [5:0]   exp_pins;
    logic         result_done;
    int           pass_count;
    int           fail_count;

    row_t rows [0:31];
    int   n_rows      = 0;
    int   cycle_count = 0;
    int   cycle_limit = 0;

    //////////////////////////////
    // clock and timeout
    //////////////////////////////

    initial begin
        wb_clk_i = 1'b0;
        forever #4 wb_clk_i = ~wb_clk_i;
    end

    always @(posedge wb_clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display("Verification failed");
            $finish;
        end
    end

    //////////////////////////////
    // dut and checker
    //////////////////////////////

    // short watchdog so the trip fits in the run
    hski2c_top #(
        .WD_STABLE_BIT (4),
        .WD_TRIP_BIT   (6)
    ) hski2c_top_inst (
        .wb_clk_i         (wb_clk_i),
        .sys_rst_i        (sys_rst_i),
        .wb_i             (wb_i),
        .pb_i             (pb_i),
        .conf_i           (conf_i),
        .sda_i            (sda_i),
        .scl_i            (scl_i),
        .hsk_enable_i     (hsk_enable_i),
        .cratebridge_en_i (cratebridge_en_i),
        .lane_up_i        (lane_up_i),
        .wb_o             (wb_o),
        .in_port_o        (in_port_o),
        .sda_t_o          (sda_t_o),
        .scl_t_o          (scl_t_o),
        .hsk_enable_t_o   (hsk_enable_t_o),
        .hsk_enable_o     (hsk_enable_o),
        .cratebridge_en_o (cratebridge_en_o),
        .interrupt_o      (interrupt_o)
    );

    hski2c_checker u_checker (
        .wb_clk_i         (wb_clk_i),
        .wb_i             (wb_i),
        .wb_o             (wb_o),
        .in_port_o        (in_port_o),
        .sda_t_o          (sda_t_o),
        .scl_t_o          (scl_t_o),
        .hsk_enable_t_o   (hsk_enable_t_o),
        .hsk_enable_o     (hsk_enable_o),
        .cratebridge_en_o (cratebridge_en_o),
        .interrupt_o      (interrupt_o),
        .check_i          (check_en),
        .wait_i           (wait_en),
        .last_i           (last_cycle),
        .name_i           (test_name),
        .exp_in_port_i    (exp_in_port),
        .exp_ctrl_i       (exp_ctrl),
        .exp_pins_i       (exp_pins),
        .done_o           (result_done),
        .pass_count_o     (pass_count),
        .fail_count_o     (fail_count)
    );

    //////////////////////////////
    // table handling
    //////////////////////////////

    task automatic add_row(input logic [127:0] name, input logic rst, input logic [2:0] strb,
                           input logic [7:0] port_id, input logic [7:0] out_port,
                           input logic wb_wr, input logic [3:0] sel, input logic [15:0] dat,
                           input logic [5:0] pins, input logic lane, input logic [7:0] cycles,
                           input logic wt, input logic [7:0] exp_in,
                           input logic [2:0] exp_c, input logic [5:0] exp_p);
        row_t r;
        r.name        = name;
        r.sys_rst     = rst;
        r.strb        = strb;
        r.port_id     = port_id;
        r.out_port    = out_port;
        r.wb_wr       = wb_wr;
        r.wb_sel      = sel;
        r.wb_dat      = dat;
        r.pins        = pins;
        r.lane_up     = lane;
        r.cycles      = cycles;
        r.wait_hit    = wt;
        r.exp_in_port = exp_in;
        r.exp_ctrl    = exp_c;
        r.exp_pins    = exp_p;
        rows[n_rows]  = r;
        n_rows        = n_rows + 1;
    endtask

    // called on a falling edge
    task automatic apply_row(input row_t r);
        sys_rst_i           = r.sys_rst;
        pb_i.port_id        = r.port_id;
        pb_i.out_port       = r.out_port;
        pb_i.write_strobe   = r.strb[2];
        pb_i.k_write_strobe = r.strb[1];
        pb_i.read_strobe    = r.strb[0];
        wb_i.cyc            = r.wb_wr;
        wb_i.stb            = r.wb_wr;
        wb_i.we             = r.wb_wr;
        wb_i.sel            = r.wb_sel;
        wb_i.adr            = 12'h000;
        wb_i.dat            = {16'h0000, r.wb_dat};
        {conf_i, scl_i, sda_i, hsk_enable_i, cratebridge_en_i} = r.pins;
        lane_up_i           = r.lane_up;
        test_name           = r.name;
        wait_en             = r.wait_hit;
        exp_in_port         = r.exp_in_port;
        exp_ctrl            = r.exp_ctrl;
        exp_pins            = r.exp_pins;
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////

    initial begin
        int   row_idx;
        int   cyc_idx;
        logic hit;
        row_t cur;

        sys_rst_i        = 1'b0;
        wb_i             = '0;
        pb_i             = '0;
        conf_i           = 2'b00;
        sda_i            = 1'b0;
        scl_i            = 1'b0;
        hsk_enable_i     = 1'b0;
        cratebridge_en_i = 1'b0;
        lane_up_i        = 1'b0;
        check_en         = 1'b0;
        wait_en          = 1'b0;
        last_cycle       = 1'b0;
        test_name        = '0;
        exp_in_port      = 8'h00;
        exp_ctrl         = 3'b000;
        exp_pins         = 6'b000000;

        // cratebridge and scl set before reset, both must be undone by it
        add_row("gc_before_rst", 1'b0, 3'b100, 8'h11, 8'h40, 1'b0, 4'h0, 16'h0000,
                6'b000000, 1'b0, 8'd1, 1'b0, 8'h00, 3'b000, 6'b110000);
        add_row("scl_before_rst", 1'b0, 3'b100, 8'h0D, 8'h00, 1'b0, 4'h0, 16'h0000,
                6'b000000, 1'b0, 8'd1, 1'b0, 8'h00, 3'b000, 6'b111010);
        // five cycles of sys_rst, processor reset is seen on the third
        add_row("rst_pulse", 1'b1, 3'b000, 8'h00, 8'h00, 1'b0, 4'h0, 16'h0000,
                6'b000000, 1'b0, 8'd3, 1'b0, 8'h00, 3'b001, 6'b101000);
        add_row("rst_release", 1'b1, 3'b000, 8'h00, 8'h00, 1'b0, 4'h0, 16'h0000,
                6'b000000, 1'b0, 8'd2, 1'b0, 8'h00, 3'b000, 6'b111000);
        // i2c through normal and k-port writes
        add_row("scl_drive_low", 1'b0, 3'b100, 8'h0D, 8'h00, 1'b0, 4'h0, 16'h0000,
                6'b000000, 1'b0, 8'd1, 1'b0, 8'h00, 3'b000, 6'b111000);
        add_row("sda_drive_low", 1'b0, 3'b100, 8'h0E, 8'h00, 1'b0, 4'h0, 16'h0000,
                6'b000000, 1'b0, 8'd1, 1'b0, 8'h00, 3'b000, 6'b101000);
        add_row("i2c_pin_read", 1'b0, 3'b001, 8'h0C, 8'h00, 1'b0, 4'h0, 16'h0000,
                6'b001100, 1'b0, 8'd2, 1'b0, 8'h03, 3'b000, 6'b001000);
        add_row("kscl_release", 1'b0, 3'b010, 8'h0D, 8'h02, 1'b0, 4'h0, 16'h0000,
                6'b000000, 1'b0, 8'd1, 1'b0, 8'h00, 3'b000, 6'b001000);
        add_row("ksda_release", 1'b0, 3'b010, 8'h0E, 8'h01, 1'b0, 4'h0, 16'h0000,
                6'b000000, 1'b0, 8'd1, 1'b0, 8'h00, 3'b000, 6'b011000);
        // k-port 5 maps to 0x85 and must not touch the bus
        add_row("kport_remap", 1'b0, 3'b010, 8'h05, 8'h00, 1'b0, 4'h0, 16'h0000,
                6'b000000, 1'b0, 8'd1, 1'b0, 8'h00, 3'b000, 6'b111000);
        // id and general control
        add_row("our_id_read", 1'b0, 3'b001, 8'h10, 8'h00, 1'b0, 4'h0, 16'h0000,
                6'b100000, 1'b0, 8'd2, 1'b0, 8'h50, 3'b000, 6'b111000);
        add_row("gc_write", 1'b0, 3'b100, 8'h11, 8'hC0, 1'b0, 4'h0, 16'h0000,
                6'b000011, 1'b0, 8'd1, 1'b0, 8'h80, 3'b000, 6'b110100);
        add_row("gc_read", 1'b0, 3'b001, 8'h11, 8'h00, 1'b0, 4'h0, 16'h0000,
                6'b000011, 1'b0, 8'd2, 1'b0, 8'hC0, 3'b010, 6'b111010);
        // wishbone control register
        add_row("wb_proc_reset", 1'b0, 3'b000, 8'h00, 8'h00, 1'b1, 4'h1, 16'h0001,
                6'b000001, 1'b0, 8'd2, 1'b0, 8'h00, 3'b010, 6'b111010);
        add_row("proc_hold_scl", 1'b0, 3'b100, 8'h0D, 8'h00, 1'b0, 4'h0, 16'h0000,
                6'b000001, 1'b0, 8'd2, 1'b0, 8'h00, 3'b011, 6'b111010);
        add_row("wb_proc_release", 1'b0, 3'b000, 8'h00, 8'h00, 1'b1, 4'h1, 16'h0000,
                6'b000001, 1'b0, 8'd2, 1'b0, 8'h00, 3'b011, 6'b111010);
        // watchdog, trip first and then mask it
        add_row("lane_up_stable", 1'b0, 3'b001, 8'h09, 8'h00, 1'b0, 4'h0, 16'h0000,
                6'b000001, 1'b1, 8'd40, 1'b0, 8'h00, 3'b010, 6'b111010);
        add_row("lane_drop_trip", 1'b0, 3'b001, 8'h09, 8'h00, 1'b0, 4'h0, 16'h0000,
                6'b000001, 1'b0, 8'd100, 1'b1, 8'h80, 3'b010, 6'b111011);
        add_row("wb_wd_disable", 1'b0, 3'b001, 8'h09, 8'h00, 1'b1, 4'h2, 16'h0100,
                6'b000001, 1'b0, 8'd2, 1'b0, 8'h80, 3'b010, 6'b111011);
        add_row("alarm_masked", 1'b0, 3'b001, 8'h09, 8'h00, 1'b0, 4'h0, 16'h0000,
                6'b000001, 1'b0, 8'd2, 1'b0, 8'h00, 3'b110, 6'b111010);

        // longest possible run plus some slack
        cycle_limit = 64;
        for (row_idx = 0; row_idx < n_rows; row_idx++) begin
            cycle_limit = cycle_limit + rows[row_idx].cycles;
        end

        @(negedge wb_clk_i);
        for (row_idx = 0; row_idx < n_rows; row_idx++) begin
            cur = rows[row_idx];
            apply_row(cur);
            cyc_idx = 0;
            hit     = 1'b0;
            while ((cyc_idx < cur.cycles) && !hit) begin
                last_cycle = (cyc_idx == cur.cycles - 1);
                check_en   = cur.wait_hit || last_cycle;
                @(posedge wb_clk_i);
                @(negedge wb_clk_i);
                hit     = cur.wait_hit && result_done;
                cyc_idx = cyc_idx + 1;
            end
        end
        check_en = 1'b0;

        $display("tests %0d, passed %0d, failed %0d", n_rows, pass_count, fail_count);
        if ((fail_count == 0) && (pass_count == n_rows)) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hski2c_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module hski2c_checker (
    input  wire                      wb_clk_i,
    input  wire hski2c_pkg::wb_req_t wb_i,
    input  wire hski2c_pkg::wb_rsp_t wb_o,
    input  wire [7:0]                in_port_o,
    input  wire                      sda_t_o,
    input  wire                      scl_t_o,
    input  wire                      hsk_enable_t_o,
    input  wire                      hsk_enable_o,
    input  wire                      cratebridge_en_o,
    input  wire                      interrupt_o,
    input  wire                      check_i,
    input  wire                      wait_i,
    input  wire                      last_i,
    input  wire [127:0]              name_i,
    input  wire [7:0]                exp_in_port_i,
    input  wire [2:0]                exp_ctrl_i,
    input  wire [5:0]                exp_pins_i,
    output logic                     done_o,
    output int                       pass_count_o,
    output int                       fail_count_o
);

    int   pass_count = 0;
    int   fail_count = 0;
    int   bus_fail   = 0;
    logic done_q     = 1'b0;
    logic req_q      = 1'b0;
    logic [2:0] got_ctrl;
    logic [5:0] got_pins;
    logic       hit;

    // wishbone readback, disable in bit 8, cratebridge bit 1, reset bit 0
    assign got_ctrl = {wb_o.dat[8], wb_o.dat[1], wb_o.dat[0]};
    assign got_pins = {sda_t_o, scl_t_o, hsk_enable_t_o, hsk_enable_o,
                       cratebridge_en_o, interrupt_o};
    assign hit      = (in_port_o == exp_in_port_i) && (got_ctrl == exp_ctrl_i) &&
                      (got_pins == exp_pins_i);

    // sampled on the rising edge, inputs move on the falling one
    always @(posedge wb_clk_i) begin
        done_q <= 1'b0;
        if (check_i && hit) begin
            pass_count <= pass_count + 1;
            done_q     <= 1'b1;
            $display("%0t ns  %s  ok", $time, name_i);
        end else if (check_i && (!wait_i || last_i)) begin
            // a waiting test only fails once its time is up
            fail_count <= fail_count + 1;
            done_q     <= 1'b1;
            $display("Fail at %0t ns: %s in_port %h exp %h, ctrl %b exp %b, pins %b exp %b",
                     $time, name_i, in_port_o, exp_in_port_i, got_ctrl, exp_ctrl_i,
                     got_pins, exp_pins_i);
        end
    end

    // ack follows the request one cycle late and drops with cyc
    always @(posedge wb_clk_i) begin
        req_q <= wb_i.cyc && wb_i.stb;
        if ((wb_o.ack !== (req_q && wb_i.cyc)) || (wb_o.err !== 1'b0) ||
            (wb_o.rty !== 1'b0)) begin
            bus_fail <= bus_fail + 1;
            $display("Fail at %0t ns: wishbone ack %b exp %b, err %b, rty %b",
                     $time, wb_o.ack, req_q && wb_i.cyc, wb_o.err, wb_o.rty);
        end
    end

    assign done_o       = done_q;
    assign pass_count_o = pass_count;
    assign fail_count_o = fail_count + bus_fail;

endmodule

`default_nettype wire

// ==== hski2c_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module hski2c_top #(
    parameter int WD_STABLE_BIT = hski2c_pkg::WD_STABLE_BIT_DEFAULT,
    parameter int WD_TRIP_BIT   = hski2c_pkg::WD_TRIP_BIT_DEFAULT
) (
    input  wire                 wb_clk_i,
    input  wire                 sys_rst_i,
    input  wire hski2c_pkg::wb_req_t wb_i,
    input  wire hski2c_pkg::pb_bus_t pb_i,
    input  wire [1:0]           conf_i,
    input  wire                 sda_i,
    input  wire                 scl_i,
    input  wire                 hsk_enable_i,
    input  wire                 cratebridge_en_i,
    input  wire                 lane_up_i,
    output hski2c_pkg::wb_rsp_t wb_o,
    output logic [7:0]          in_port_o,
    output logic                sda_t_o,
    output logic                scl_t_o,
    output logic                hsk_enable_t_o,
    output logic                hsk_enable_o,
    output logic                cratebridge_en_o,
    output logic                interrupt_o
);

    logic processor_reset;
    logic sys_reset_flag;
    logic watchdog_disable;
    logic wd_alarm;
    logic cratebridge_actual;

    // wishbone register and reset sequencing
    hsk_wb_ctrl u_wb_ctrl (
        .wb_clk_i             (wb_clk_i),
        .sys_rst_i            (sys_rst_i),
        .wb_i                 (wb_i),
        .cratebridge_actual_i (cratebridge_actual),
        .wb_o                 (wb_o),
        .processor_reset_o    (processor_reset),
        .sys_reset_flag_o     (sys_reset_flag),
        .watchdog_disable_o   (watchdog_disable)
    );

    // turf lane watchdog
    hsk_watchdog #(
        .WD_STABLE_BIT (WD_STABLE_BIT),
        .WD_TRIP_BIT   (WD_TRIP_BIT)
    ) u_watchdog (
        .wb_clk_i           (wb_clk_i),
        .lane_up_i          (lane_up_i),
        .watchdog_disable_i (watchdog_disable),
        .wd_alarm_o         (wd_alarm)
    );

    // processor io ports
    hsk_port_decode u_port_decode (
        .wb_clk_i             (wb_clk_i),
        .processor_reset      (processor_reset),
        .sys_reset_flag_i     (sys_reset_flag),
        .pb_i                 (pb_i),
        .conf_i               (conf_i),
        .sda_i                (sda_i),
        .scl_i                (scl_i),
        .hsk_enable_i         (hsk_enable_i),
        .cratebridge_en_i     (cratebridge_en_i),
        .wd_alarm_i           (wd_alarm),
        .in_port_o            (in_port_o),
        .sda_t_o              (sda_t_o),
        .scl_t_o              (scl_t_o),
        .hsk_enable_t_o       (hsk_enable_t_o),
        .hsk_enable_o         (hsk_enable_o),
        .cratebridge_en_o     (cratebridge_en_o),
        .cratebridge_actual_o (cratebridge_actual)
    );

    // only source left on the processor interrupt
    assign interrupt_o = wd_alarm;

endmodule

`default_nettype wire

// ==== hsk_port_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module hsk_port_decode (
    input  wire                 wb_clk_i,
    input  wire                 processor_reset,
    input  wire                 sys_reset_flag_i,
    input  wire hski2c_pkg::pb_bus_t pb_i,
    input  wire [1:0]           conf_i,
    input  wire                 sda_i,
    input  wire                 scl_i,
    input  wire                 hsk_enable_i,
    input  wire                 cratebridge_en_i,
    input  wire                 wd_alarm_i,
    output logic [7:0]          in_port_o,
    output logic                sda_t_o,
    output logic                scl_t_o,
    output logic                hsk_enable_t_o,
    output logic                hsk_enable_o,
    output logic                cratebridge_en_o,
    output logic                cratebridge_actual_o
);

    //////////////////////////////
    // write decode
    //////////////////////////////

    // k-ports only carry a 4-bit id
    // !bit3 goes to the top so 0x0-0x7 land in the upper half
    logic [7:0] kport_id;
    logic       any_write;
    logic       scl_write;
    logic       sda_write;
    logic       gc_write;

    assign kport_id  = pb_i.k_write_strobe ?
                       {~pb_i.port_id[3], 3'b000, pb_i.port_id[3:0]} : pb_i.port_id;
    assign any_write = pb_i.write_strobe || pb_i.k_write_strobe;

    assign scl_write = any_write &&
                       ((kport_id & hski2c_pkg::PB_MASK_SCL) == hski2c_pkg::SCL_PORT);
    assign sda_write = any_write &&
                       ((kport_id & hski2c_pkg::PB_MASK_SDA) == hski2c_pkg::SDA_PORT);
    // general control only through a normal output
    assign gc_write  = pb_i.write_strobe &&
                       ((pb_i.port_id & hski2c_pkg::PB_MASK_OURID) ==
                        hski2c_pkg::GENERAL_CONTROL_PORT);

    //////////////////////////////
    // i2c open-drain tristates
    //////////////////////////////

    // 1 = released, line pulled up externally
    logic scl_tristate = 1'b1;
    logic sda_tristate = 1'b1;

    always_ff @(posedge wb_clk_i) begin
        // holding the processor also lets go of the bus
        if (processor_reset) begin
            scl_tristate <= 1'b1;
            sda_tristate <= 1'b1;
        end else begin
            if (scl_write) begin
                scl_tristate <= pb_i.out_port[hski2c_pkg::SCL_BIT];
            end
            if (sda_write) begin
                sda_tristate <= pb_i.out_port[hski2c_pkg::SDA_BIT];
            end
        end
    end

    assign scl_t_o = scl_tristate;
    assign sda_t_o = sda_tristate;

    //////////////////////////////
    // general control
    //////////////////////////////

    logic cratebridge_enable        = 1'b0;
    logic cratebridge_enable_actual = 1'b0;

    always_ff @(posedge wb_clk_i) begin
        // only a turf reset clears it, processor reset leaves it alone
        if (sys_reset_flag_i) begin
            cratebridge_enable <= 1'b0;
        end else if (gc_write) begin
            cratebridge_enable <= pb_i.out_port[hski2c_pkg::GC_CRATEBRIDGE_BIT];
        end
        // what the pin really does
        cratebridge_enable_actual <= cratebridge_en_i;
    end

    assign cratebridge_en_o     = cratebridge_enable;
    assign cratebridge_actual_o = cratebridge_enable_actual;

    // enable line driven only during the write cycle
    assign hsk_enable_t_o = !gc_write;
    assign hsk_enable_o   = pb_i.out_port[hski2c_pkg::GC_ENABLE_BIT];

    //////////////////////////////
    // read decode
    //////////////////////////////

    hski2c_pkg::pb_port_e rd_sel;

    always_comb begin
        if ((pb_i.port_id & hski2c_pkg::PB_MASK_STATUS) == hski2c_pkg::STATUS_PORT) begin
            rd_sel = hski2c_pkg::PORT_STATUS;
        end else if ((pb_i.port_id & hski2c_pkg::PB_MASK_SDA) ==
                     (hski2c_pkg::SCL_PORT & hski2c_pkg::PB_MASK_SDA)) begin
            // pins read back at 0x0C and 0x0D
            rd_sel = hski2c_pkg::PORT_I2C;
        end else if ((pb_i.port_id & hski2c_pkg::PB_MASK_OURID) ==
                     hski2c_pkg::OUR_ID_PORT) begin
            rd_sel = hski2c_pkg::PORT_OUR_ID;
        end else if ((pb_i.port_id & hski2c_pkg::PB_MASK_OURID) ==
                     hski2c_pkg::GENERAL_CONTROL_PORT) begin
            rd_sel = hski2c_pkg::PORT_GEN_CTRL;
        end else begin
            rd_sel = hski2c_pkg::PORT_NONE;
        end
    end

    always_comb begin
        in_port_o = 8'h00;
        case (rd_sel)
            hski2c_pkg::PORT_STATUS: in_port_o[hski2c_pkg::STATUS_WD_BIT] = wd_alarm_i;
            hski2c_pkg::PORT_I2C: begin
                in_port_o[hski2c_pkg::SCL_BIT] = scl_i;
                in_port_o[hski2c_pkg::SDA_BIT] = sda_i;
            end
            // 0x40 + conf<<3
            hski2c_pkg::PORT_OUR_ID: in_port_o = {hski2c_pkg::OUR_ID_PREFIX, conf_i, 3'b000};
            hski2c_pkg::PORT_GEN_CTRL: begin
                in_port_o[hski2c_pkg::GC_ENABLE_BIT]      = hsk_enable_i;
                in_port_o[hski2c_pkg::GC_CRATEBRIDGE_BIT] = cratebridge_enable_actual;
            end
            default: in_port_o = 8'h00;
        endcase
    end

    i2c_release_a : assert property (@(posedge wb_clk_i)
        processor_reset |=> (sda_t_o && scl_t_o));

endmodule

`default_nettype wire

// ==== hsk_watchdog.sv ====
`timescale 1ns/10ps
`default_nettype none

module hsk_watchdog #(
    parameter int WD_STABLE_BIT = hski2c_pkg::WD_STABLE_BIT_DEFAULT,
    parameter int WD_TRIP_BIT   = hski2c_pkg::WD_TRIP_BIT_DEFAULT
) (
    input  wire  wb_clk_i,
    input  wire  lane_up_i,
    input  wire  watchdog_disable_i,
    output logic wd_alarm_o
);

    //////////////////////////////
    // lane-down counter
    //////////////////////////////

    // sequence:
    //   lane down, not stable   counter held at zero
    //   lane up, not stable     counter runs until the stable bit
    //   lane up, armed          counter held at zero
    //   lane down, armed        counter runs until the trip bit
    logic [hski2c_pkg::WD_COUNTER_WIDTH-1:0] lane_down_count = '0;
    hski2c_pkg::wd_state_e                   wd_state = hski2c_pkg::WD_WAIT_STABLE;
    logic                                    count_clear;

    assign count_clear = ((wd_state == hski2c_pkg::WD_WAIT_STABLE) && !lane_up_i) ||
                         ((wd_state == hski2c_pkg::WD_ARMED) && lane_up_i);

    always_ff @(posedge wb_clk_i) begin
        if (count_clear) begin
            lane_down_count <= '0;
        end else begin
            lane_down_count <= lane_down_count + 1'b1;
        end
    end

    //////////////////////////////
    // trip state machine
    //////////////////////////////

    always_ff @(posedge wb_clk_i) begin
        case (wd_state)
            hski2c_pkg::WD_WAIT_STABLE: begin
                // lane has been up long enough to trust it
                if (lane_down_count[WD_STABLE_BIT] && lane_up_i) begin
                    wd_state <= hski2c_pkg::WD_ARMED;
                end
            end
            hski2c_pkg::WD_ARMED: begin
                if (lane_down_count[WD_TRIP_BIT]) begin
                    wd_state <= hski2c_pkg::WD_TRIPPED;
                end
            end
            // sticky until power cycle
            hski2c_pkg::WD_TRIPPED: wd_state <= hski2c_pkg::WD_TRIPPED;
            default:                wd_state <= hski2c_pkg::WD_WAIT_STABLE;
        endcase
    end

    // disable masks the alarm but the trip is still remembered
    assign wd_alarm_o = (wd_state == hski2c_pkg::WD_TRIPPED) && !watchdog_disable_i;

    tripped_sticky_a : assert property (@(posedge wb_clk_i)
        (wd_state == hski2c_pkg::WD_TRIPPED) |=> (wd_state == hski2c_pkg::WD_TRIPPED));

endmodule

`default_nettype wire

// ==== hsk_wb_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module hsk_wb_ctrl (
    input  wire                 wb_clk_i,
    input  wire                 sys_rst_i,
    input  wire hski2c_pkg::wb_req_t wb_i,
    input  wire                 cratebridge_actual_i,
    output hski2c_pkg::wb_rsp_t wb_o,
    output logic                processor_reset_o,
    output logic                sys_reset_flag_o,
    output logic                watchdog_disable_o
);

    //////////////////////////////
    // system reset edge
    //////////////////////////////

    // two-stage history of the turf reset
    logic [1:0] sys_reset_rereg = 2'b00;
    // high for one cycle at the rising edge
    assign sys_reset_flag_o = (sys_reset_rereg == 2'b01);

    //////////////////////////////
    // control register
    //////////////////////////////

    logic ack_q            = 1'b0;
    logic processor_reset_q = 1'b0;
    logic watchdog_disable_q = 1'b0;
    logic wb_write;

    // write lands on the second cycle of the access, once ack is out
    assign wb_write = wb_i.cyc && wb_i.stb && wb_i.we && ack_q;

    always_ff @(posedge wb_clk_i) begin
        sys_reset_rereg <= {sys_reset_rereg[0], sys_rst_i};

        // during a system reset the processor pulses reset once,
        // then comes back out while sys_rst_i is still high
        if (sys_reset_rereg[0]) begin
            processor_reset_q <= sys_reset_flag_o;
        end else if (wb_write && wb_i.sel[0]) begin
            processor_reset_q <= wb_i.dat[hski2c_pkg::WB_PROC_RESET_BIT];
        end

        if (wb_write && wb_i.sel[1]) begin
            watchdog_disable_q <= wb_i.dat[hski2c_pkg::WB_WD_DISABLE_BIT];
        end

        ack_q <= wb_i.cyc && wb_i.stb;
    end

    assign processor_reset_o  = processor_reset_q;
    assign watchdog_disable_o = watchdog_disable_q;

    // readback, cratebridge shows the real pin state
    always_comb begin
        wb_o = '0;
        wb_o.ack = ack_q && wb_i.cyc;
        wb_o.dat[hski2c_pkg::WB_PROC_RESET_BIT]  = processor_reset_q;
        wb_o.dat[hski2c_pkg::WB_CRATEBRIDGE_BIT] = cratebridge_actual_i;
        wb_o.dat[hski2c_pkg::WB_WD_DISABLE_BIT]  = watchdog_disable_q;
    end

    // a system reset gives the processor exactly one reset cycle
    sys_reset_pulse_a : assert property (@(posedge wb_clk_i)
        sys_reset_flag_o |=> processor_reset_o ##1 (!processor_reset_o || !sys_rst_i));

endmodule

`default_nettype wire

// ==== hski2c_pkg.sv ====
`default_nettype none

package hski2c_pkg;

    //////////////////////////////
    // processor port map
    //////////////////////////////

    // 0x08-0x0B held the uart, only the status read survives
    localparam logic [7:0] STATUS_PORT          = 8'h09;
    // 0x0C-0x0F is the i2c block
    localparam logic [7:0] SCL_PORT             = 8'h0D;
    localparam logic [7:0] SDA_PORT             = 8'h0E;
    localparam logic [7:0] OUR_ID_PORT          = 8'h10;
    localparam logic [7:0] GENERAL_CONTROL_PORT = 8'h11;

    // bit 7 is always in the masks so the upper half never aliases
    // status matches 0x09 and 0x0B
    localparam logic [7:0] PB_MASK_STATUS = 8'b1001_1101;
    // scl matches 0x0D and 0x0F
    localparam logic [7:0] PB_MASK_SCL    = 8'b1001_1101;
    // sda matches 0x0E and 0x0F, also used for the 0x0C/0x0D pin read
    localparam logic [7:0] PB_MASK_SDA    = 8'b1001_1110;
    // splits 0x10 (our id) from 0x11 (general control)
    localparam logic [7:0] PB_MASK_OURID  = 8'b1001_0001;

    //////////////////////////////
    // bit positions
    //////////////////////////////

    localparam int SCL_BIT            = 1;
    localparam int SDA_BIT            = 0;
    // general control port
    localparam int GC_ENABLE_BIT      = 7;
    localparam int GC_CRATEBRIDGE_BIT = 6;
    // status port
    localparam int STATUS_WD_BIT      = 7;
    // wishbone control register
    localparam int WB_PROC_RESET_BIT  = 0;
    localparam int WB_CRATEBRIDGE_BIT = 1;
    localparam int WB_WD_DISABLE_BIT  = 8;

    // top bits of the id byte, conf sits below it
    localparam logic [2:0] OUR_ID_PREFIX = 3'b010;

    // watchdog counter, stable at ~1.6 ms and trip at ~3.35 s with an 80 MHz clock
    localparam int WD_COUNTER_WIDTH      = 48;
    localparam int WD_STABLE_BIT_DEFAULT = 17;
    localparam int WD_TRIP_BIT_DEFAULT   = 28;

    //////////////////////////////
    // buses and states
    //////////////////////////////

    // processor output side of the io bus
    typedef struct packed {
        logic [7:0] port_id;
        logic [7:0] out_port;
        logic       write_strobe;
        logic       k_write_strobe;
        logic       read_strobe;
    } pb_bus_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  sel;
        logic [11:0] adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic        err;
        logic        rty;
        logic [31:0] dat;
    } wb_rsp_t;

    // which source drives in_port
    typedef enum logic [2:0] {
        PORT_STATUS,
        PORT_I2C,
        PORT_OUR_ID,
        PORT_GEN_CTRL,
        PORT_NONE
    } pb_port_e;

    typedef enum logic [1:0] {
        WD_WAIT_STABLE,
        WD_ARMED,
        WD_TRIPPED
    } wd_state_e;

endpackage

`default_nettype wire
